//--- hdl/mazePkg.sv
package mazePkg;

    // Grid size
    localparam int MazeRows = 10;
    localparam int MazeColumns = 20;

    // Wide enough to also hold the parked value of a debris slot
    typedef logic [4:0] rowT;
    typedef logic [4:0] columnT;

    // Cell codes as stored in the maze rows
    localparam logic [3:0] CellFree = 4'h6;
    localparam logic [3:0] CellWall = 4'h5;

    // Row and column of a debris slot that is off the maze
    localparam int ParkedPosition = 20;

    localparam int DebrisKinds = 3;

    // One nibble per cell with column 0 in the top nibble
    localparam logic [0:MazeRows-1][79:0] MazeLayout = '{
        80'h55555555555555555555,
        80'h56665666666666665555,
        80'h56565656555555565555,
        80'h56565656666666666665,
        80'h56565656555555565555,
        80'h56566656555555565555,
        80'h56565556555555565555,
        80'h56565556555555565555,
        80'h56565556555555565555,
        80'h56666666666666665555
    };

    // Anything off the grid reads as wall
    function automatic logic [3:0] cellAt(input rowT row, input columnT column);
        int lowBit;
        if (int'(row) >= MazeRows || int'(column) >= MazeColumns) begin
            return CellWall;
        end
        lowBit = 4 * (MazeColumns - 1 - int'(column));
        return MazeLayout[row][lowBit +: 4];
    endfunction

endpackage

//--- hdl/robotPkg.sv
package robotPkg;

    // Robot heading
    typedef enum logic [1:0] {
        North = 2'd0,
        South = 2'd1,
        East  = 2'd2,
        West  = 2'd3
    } headingT;

    // Bit positions in the gamepad word
    localparam int ButtonUp = 0;
    localparam int ButtonDown = 1;
    localparam int ButtonLeft = 2;
    localparam int ButtonRight = 3;
    localparam int ButtonA = 4;
    localparam int ButtonB = 5;
    localparam int ButtonX = 7;
    localparam int ButtonY = 8;
    localparam int ButtonZ = 9;

    // Remaining hits on the debris in front of the robot
    typedef logic [3:0] lifeT;

endpackage

//--- hdl/frameTiming.sv
`timescale 1ns/1ps

module frameTiming #(
    parameter int ReadFrames = 5,
    parameter int RobotFrames = 9
) (
    input  logic Clock50,
    input  logic reset,
    input  logic vSync,
    output logic readTick,
    output logic senseTick,
    output logic moveTick
);

    localparam int ReadWidth = $clog2(ReadFrames + 1);
    localparam int RobotWidth = $clog2(RobotFrames + 1);

    logic syncFirst;
    logic syncSecond;
    logic frameTick;
    logic pendingMove;
    // Frames seen so far modulo the period
    logic [ReadWidth-1:0] readCount;
    logic [RobotWidth-1:0] robotCount;
    logic readDue;
    logic senseDue;

    always_ff @(posedge Clock50) begin
        syncFirst <= vSync;
        syncSecond <= syncFirst;
    end

    assign frameTick = syncFirst & ~syncSecond;

    // Next frame number n gives n mod ReadFrames == 1 and n mod RobotFrames == 0
    assign readDue = (readCount == '0);
    assign senseDue = (robotCount == RobotWidth'(RobotFrames - 1));

    always_ff @(posedge Clock50) begin
        if (reset) begin
            readCount <= '0;
            robotCount <= '0;
            pendingMove <= 1'b0;
            readTick <= 1'b0;
            senseTick <= 1'b0;
            moveTick <= 1'b0;
        end else if (frameTick) begin
            readTick <= readDue;
            senseTick <= senseDue;
            moveTick <= pendingMove;
            pendingMove <= senseDue;
            readCount <= (readCount == ReadWidth'(ReadFrames - 1)) ? '0 : readCount + 1'b1;
            robotCount <= senseDue ? '0 : robotCount + 1'b1;
        end else begin
            readTick <= 1'b0;
            senseTick <= 1'b0;
            moveTick <= 1'b0;
        end
    end

endmodule

//--- hdl/commandReader.sv
`timescale 1ns/1ps

module commandReader
    import mazePkg::*;
    import robotPkg::*;
(
    input  logic Clock50,
    input  logic reset,
    input  logic readTick,
    input  logic [11:0] gamepad,
    output rowT cursorRow,
    output columnT cursorColumn,
    output logic placeRobot,
    output logic placeMarker,
    output logic [2:0] placeDebris
);

    logic [11:0] heldButtons;
    logic commandValid;

    // Gamepad word held for the command cycle
    always_ff @(posedge Clock50) begin
        if (readTick) begin
            heldButtons <= gamepad;
        end
    end

    always_ff @(posedge Clock50) begin
        if (reset) begin
            commandValid <= 1'b0;
        end else begin
            commandValid <= readTick;
        end
    end

    // Requests go out while the cursor still shows the old cell
    assign placeRobot = commandValid & heldButtons[ButtonA];
    assign placeMarker = commandValid & heldButtons[ButtonB];
    assign placeDebris = {3{commandValid}} &
        {heldButtons[ButtonZ], heldButtons[ButtonY], heldButtons[ButtonX]};

    always_ff @(posedge Clock50) begin
        if (reset) begin
            cursorRow <= rowT'(3);
            cursorColumn <= columnT'(10);
        end else if (commandValid) begin
            if (heldButtons[ButtonUp]) begin
                cursorRow <= (cursorRow == '0) ? rowT'(MazeRows - 1) : cursorRow - 1'b1;
            end else if (heldButtons[ButtonDown]) begin
                cursorRow <= (cursorRow == rowT'(MazeRows - 1)) ? '0 : cursorRow + 1'b1;
            end

            if (heldButtons[ButtonLeft]) begin
                cursorColumn <= (cursorColumn == '0) ?
                    columnT'(MazeColumns - 1) : cursorColumn - 1'b1;
            end else if (heldButtons[ButtonRight]) begin
                cursorColumn <= (cursorColumn == columnT'(MazeColumns - 1)) ?
                    '0 : cursorColumn + 1'b1;
            end
        end
    end

endmodule

//--- hdl/worldState.sv
`timescale 1ns/1ps

module worldState
    import mazePkg::*;
(
    input  logic Clock50,
    input  logic reset,
    input  rowT cursorRow,
    input  columnT cursorColumn,
    input  logic placeMarker,
    input  logic [2:0] placeDebris,
    input  logic [2:0] clearDebris,
    output rowT markerRow,
    output columnT markerColumn,
    output rowT debrisRows [DebrisKinds],
    output columnT debrisColumns [DebrisKinds]
);

    logic cursorFree;
    logic [DebrisKinds-1:0] slotParked;

    assign cursorFree = (cellAt(cursorRow, cursorColumn) == CellFree);

    always_comb begin
        for (int k = 0; k < DebrisKinds; k++) begin
            slotParked[k] = (debrisRows[k] == rowT'(ParkedPosition)) &&
                (debrisColumns[k] == columnT'(ParkedPosition));
        end
    end

    // Marker only lands on open floor
    always_ff @(posedge Clock50) begin
        if (reset) begin
            markerRow <= rowT'(3);
            markerColumn <= columnT'(18);
        end else if (placeMarker && cursorFree) begin
            markerRow <= cursorRow;
            markerColumn <= cursorColumn;
        end
    end

    always_ff @(posedge Clock50) begin
        if (reset) begin
            for (int k = 0; k < DebrisKinds; k++) begin
                debrisRows[k] <= rowT'(ParkedPosition);
                debrisColumns[k] <= columnT'(ParkedPosition);
            end
        end else begin
            for (int k = 0; k < DebrisKinds; k++) begin
                if (clearDebris[k]) begin
                    debrisRows[k] <= rowT'(ParkedPosition);
                    debrisColumns[k] <= columnT'(ParkedPosition);
                end else if (placeDebris[k] && slotParked[k] && cursorFree) begin
                    // One piece of each kind on the maze at a time
                    debrisRows[k] <= cursorRow;
                    debrisColumns[k] <= cursorColumn;
                end
            end
        end
    end

endmodule

//--- hdl/robotCore.sv
`timescale 1ns/1ps

module robotCore
    import mazePkg::*;
    import robotPkg::*;
#(
    parameter int LightLife = 3,
    parameter int MediumLife = 6,
    parameter int HeavyLife = 9
) (
    input  logic Clock50,
    input  logic reset,
    input  logic senseTick,
    input  logic moveTick,
    input  logic placeRobot,
    input  rowT cursorRow,
    input  columnT cursorColumn,
    input  rowT markerRow,
    input  columnT markerColumn,
    input  rowT debrisRows [DebrisKinds],
    input  columnT debrisColumns [DebrisKinds],
    input  logic avancar,
    input  logic girar,
    input  logic remover,
    output logic head,
    output logic left,
    output logic under,
    output logic barrier,
    output logic robotActive,
    output rowT robotRow,
    output columnT robotColumn,
    output headingT robotHeading,
    output logic [2:0] clearDebris
);

    localparam lifeT KindLife [DebrisKinds] = '{
        lifeT'(LightLife),
        lifeT'(MediumLife),
        lifeT'(HeavyLife)
    };

    rowT aheadRow;
    columnT aheadColumn;
    rowT sideRow;
    columnT sideColumn;
    logic aheadValid;
    logic sideValid;
    logic headWall;
    logic sideWall;
    logic onMarker;
    logic placeAllowed;
    logic [DebrisKinds-1:0] debrisAhead;
    logic [DebrisKinds-1:0] pickAhead;
    lifeT lifeAhead;
    lifeT lifeCount;

    // Cell in front and cell to the left of the current heading
    always_comb begin
        aheadRow = robotRow;
        aheadColumn = robotColumn;
        sideRow = robotRow;
        sideColumn = robotColumn;
        aheadValid = 1'b1;
        sideValid = 1'b1;
        case (robotHeading)
            North: begin
                aheadValid = (robotRow != '0);
                aheadRow = robotRow - 1'b1;
                sideValid = (robotColumn != '0);
                sideColumn = robotColumn - 1'b1;
            end
            South: begin
                aheadValid = (robotRow != rowT'(MazeRows - 1));
                aheadRow = robotRow + 1'b1;
                sideValid = (robotColumn != columnT'(MazeColumns - 1));
                sideColumn = robotColumn + 1'b1;
            end
            East: begin
                aheadValid = (robotColumn != columnT'(MazeColumns - 1));
                aheadColumn = robotColumn + 1'b1;
                sideValid = (robotRow != '0);
                sideRow = robotRow - 1'b1;
            end
            default: begin
                aheadValid = (robotColumn != '0);
                aheadColumn = robotColumn - 1'b1;
                sideValid = (robotRow != rowT'(MazeRows - 1));
                sideRow = robotRow + 1'b1;
            end
        endcase
    end

    // Maze edge counts as wall
    assign headWall = !aheadValid || (cellAt(aheadRow, aheadColumn) == CellWall);
    assign sideWall = !sideValid || (cellAt(sideRow, sideColumn) == CellWall);
    assign onMarker = (robotRow == markerRow) && (robotColumn == markerColumn);
    assign placeAllowed = (cellAt(cursorRow, cursorColumn) == CellFree) ||
        ((cursorRow == markerRow) && (cursorColumn == markerColumn));

    always_comb begin
        pickAhead = '0;
        lifeAhead = '0;
        for (int k = 0; k < DebrisKinds; k++) begin
            debrisAhead[k] = aheadValid && (debrisRows[k] == aheadRow) &&
                (debrisColumns[k] == aheadColumn);
        end
        // Lightest kind wins if slots overlap
        for (int k = DebrisKinds - 1; k >= 0; k--) begin
            if (debrisAhead[k]) begin
                pickAhead = '0;
                pickAhead[k] = 1'b1;
                lifeAhead = KindLife[k];
            end
        end
    end

    always_ff @(posedge Clock50) begin
        if (reset) begin
            head <= 1'b0;
            left <= 1'b0;
            under <= 1'b0;
            barrier <= 1'b0;
            robotActive <= 1'b0;
            lifeCount <= '0;
            clearDebris <= '0;
        end else begin
            clearDebris <= '0;
            if (senseTick) begin
                head <= headWall;
                left <= sideWall;
                under <= onMarker;
                barrier <= |debrisAhead;
                robotActive <= 1'b1;
                if (|debrisAhead && lifeCount == '0) begin
                    lifeCount <= lifeAhead;
                end
            end
            if (moveTick) begin
                robotActive <= 1'b0;
                if (remover && lifeCount != '0) begin
                    lifeCount <= lifeCount - 1'b1;
                    // Last hit removes it
                    if (lifeCount == lifeT'(1)) begin
                        clearDebris <= pickAhead;
                    end
                end
            end
        end
    end

    always_ff @(posedge Clock50) begin
        if (reset) begin
            robotRow <= rowT'(3);
            robotColumn <= columnT'(18);
            robotHeading <= East;
        end else if (placeRobot && placeAllowed) begin
            robotRow <= cursorRow;
            robotColumn <= cursorColumn;
        end else if (moveTick) begin
            if (avancar) begin
                if (aheadValid) begin
                    robotRow <= aheadRow;
                    robotColumn <= aheadColumn;
                end
            end else if (girar) begin
                case (robotHeading)
                    North: robotHeading <= West;
                    West: robotHeading <= South;
                    South: robotHeading <= East;
                    default: robotHeading <= North;
                endcase
            end
        end
    end

endmodule

//--- hdl/robotMazeTop.sv
`timescale 1ns/1ps

module robotMazeTop
    import mazePkg::*;
    import robotPkg::*;
#(
    parameter int ReadFrames = 5,
    parameter int RobotFrames = 9,
    parameter int LightLife = 3,
    parameter int MediumLife = 6,
    parameter int HeavyLife = 9
) (
    input  logic Clock50,
    input  logic reset,
    input  logic vSync,
    input  logic [11:0] gamepad,
    input  logic avancar,
    input  logic girar,
    input  logic remover,
    output logic head,
    output logic left,
    output logic under,
    output logic barrier,
    output logic robotActive,
    output rowT robotRow,
    output columnT robotColumn,
    output headingT robotHeading,
    output rowT cursorRow,
    output columnT cursorColumn,
    output rowT markerRow,
    output columnT markerColumn,
    output rowT debrisRows [DebrisKinds],
    output columnT debrisColumns [DebrisKinds]
);

    logic readTick;
    logic senseTick;
    logic moveTick;
    logic placeRobot;
    logic placeMarker;
    logic [2:0] placeDebris;
    logic [2:0] clearDebris;

    frameTiming #(
        .ReadFrames(ReadFrames),
        .RobotFrames(RobotFrames)
    ) frameTiming0 (
        .Clock50(Clock50),
        .reset(reset),
        .vSync(vSync),
        .readTick(readTick),
        .senseTick(senseTick),
        .moveTick(moveTick)
    );

    commandReader commandReader0 (
        .Clock50(Clock50),
        .reset(reset),
        .readTick(readTick),
        .gamepad(gamepad),
        .cursorRow(cursorRow),
        .cursorColumn(cursorColumn),
        .placeRobot(placeRobot),
        .placeMarker(placeMarker),
        .placeDebris(placeDebris)
    );

    // Scene between the reader and the robot
    worldState worldState0 (
        .Clock50(Clock50),
        .reset(reset),
        .cursorRow(cursorRow),
        .cursorColumn(cursorColumn),
        .placeMarker(placeMarker),
        .placeDebris(placeDebris),
        .clearDebris(clearDebris),
        .markerRow(markerRow),
        .markerColumn(markerColumn),
        .debrisRows(debrisRows),
        .debrisColumns(debrisColumns)
    );

    robotCore #(
        .LightLife(LightLife),
        .MediumLife(MediumLife),
        .HeavyLife(HeavyLife)
    ) robotCore0 (
        .Clock50(Clock50),
        .reset(reset),
        .senseTick(senseTick),
        .moveTick(moveTick),
        .placeRobot(placeRobot),
        .cursorRow(cursorRow),
        .cursorColumn(cursorColumn),
        .markerRow(markerRow),
        .markerColumn(markerColumn),
        .debrisRows(debrisRows),
        .debrisColumns(debrisColumns),
        .avancar(avancar),
        .girar(girar),
        .remover(remover),
        .head(head),
        .left(left),
        .under(under),
        .barrier(barrier),
        .robotActive(robotActive),
        .robotRow(robotRow),
        .robotColumn(robotColumn),
        .robotHeading(robotHeading),
        .clearDebris(clearDebris)
    );

endmodule

//--- sim/robotMazeTb.sv
`timescale 1ns/1ps

module robotMazeTb
    import mazePkg::*;
    import robotPkg::*;
();

    localparam int ReadFrames = 5;
    localparam int RobotFrames = 9;
    localparam int ActiveTimeout = 20;

    logic Clock50;
    logic reset;
    logic vSync;
    logic [11:0] gamepad;
    logic avancar;
    logic girar;
    logic remover;
    logic head;
    logic left;
    logic under;
    logic barrier;
    logic robotActive;
    rowT robotRow;
    columnT robotColumn;
    headingT robotHeading;
    rowT cursorRow;
    columnT cursorColumn;
    rowT markerRow;
    columnT markerColumn;
    rowT debrisRows [DebrisKinds];
    columnT debrisColumns [DebrisKinds];

    // Expected scene
    int curRow;
    int curCol;
    int robRow;
    int robCol;
    headingT robHead;
    int mkRow;
    int mkCol;
    int dbRow [DebrisKinds];
    int dbCol [DebrisKinds];
    int lifeModel;
    int frameCount;
    int errorCount;
    int checkCount;
    string testName;

    robotMazeTop #(
        .ReadFrames(ReadFrames),
        .RobotFrames(RobotFrames),
        .LightLife(3),
        .MediumLife(6),
        .HeavyLife(9)
    ) dut0 (
        .Clock50(Clock50),
        .reset(reset),
        .vSync(vSync),
        .gamepad(gamepad),
        .avancar(avancar),
        .girar(girar),
        .remover(remover),
        .head(head),
        .left(left),
        .under(under),
        .barrier(barrier),
        .robotActive(robotActive),
        .robotRow(robotRow),
        .robotColumn(robotColumn),
        .robotHeading(robotHeading),
        .cursorRow(cursorRow),
        .cursorColumn(cursorColumn),
        .markerRow(markerRow),
        .markerColumn(markerColumn),
        .debrisRows(debrisRows),
        .debrisColumns(debrisColumns)
    );

    always #5 Clock50 = ~Clock50;

    function automatic logic offGrid(input int row, input int col);
        return row < 0 || row >= MazeRows || col < 0 || col >= MazeColumns;
    endfunction

    // Edge of the maze reads as wall
    function automatic logic blocked(input int row, input int col);
        if (offGrid(row, col)) begin
            return 1'b1;
        end
        return cellAt(rowT'(row), columnT'(col)) == CellWall;
    endfunction

    function automatic logic freeCell(input int row, input int col);
        if (offGrid(row, col)) begin
            return 1'b0;
        end
        return cellAt(rowT'(row), columnT'(col)) == CellFree;
    endfunction

    function automatic int rowStep(input headingT h);
        return (h == North) ? -1 : (h == South) ? 1 : 0;
    endfunction

    function automatic int columnStep(input headingT h);
        return (h == East) ? 1 : (h == West) ? -1 : 0;
    endfunction

    function automatic headingT turnedLeft(input headingT h);
        case (h)
            North: return West;
            West: return South;
            South: return East;
            default: return North;
        endcase
    endfunction

    function automatic int debrisAt(input int row, input int col);
        for (int k = 0; k < DebrisKinds; k++) begin
            if (dbRow[k] == row && dbCol[k] == col) begin
                return k;
            end
        end
        return -1;
    endfunction

    function automatic int lifeOf(input int kind);
        return (kind == 0) ? 3 : (kind == 1) ? 6 : 9;
    endfunction

    function automatic logic isRead(input int n);
        return (n % ReadFrames) == 1;
    endfunction

    function automatic logic isSense(input int n);
        return (n % RobotFrames) == 0;
    endfunction

    function automatic logic isMove(input int n);
        return (n % RobotFrames) == 1 && n > RobotFrames;
    endfunction

    task automatic finishRun();
        $display("%0d errors in %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    task automatic expectEqual(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERR %s %s: expected %0d actual %0d", testName, what, expected, actual);
        end
    endtask

    // One video frame with inputs held throughout
    task automatic runFrame(input logic [11:0] buttons, input logic fwd, input logic turn,
                            input logic wear);
        gamepad = buttons;
        avancar = fwd;
        girar = turn;
        remover = wear;
        vSync = 1'b1;
        repeat (4) @(posedge Clock50);
        #1;
        vSync = 1'b0;
        repeat (4) @(posedge Clock50);
        #1;
        gamepad = '0;
        avancar = 1'b0;
        girar = 1'b0;
        remover = 1'b0;
        frameCount++;
    endtask

    task automatic awaitActive(input logic level);
        int waited;
        waited = 0;
        while (robotActive !== level && waited < ActiveTimeout) begin
            @(posedge Clock50);
            #1;
            waited++;
        end
        if (robotActive !== level) begin
            $display("Timeout in %s: robotActive never went to %0d", testName, level);
            errorCount++;
            finishRun();
        end
    endtask

    task automatic checkScene();
        expectEqual("cursor row", curRow, cursorRow);
        expectEqual("cursor column", curCol, cursorColumn);
        expectEqual("robot row", robRow, robotRow);
        expectEqual("robot column", robCol, robotColumn);
        expectEqual("robot heading", robHead, robotHeading);
        expectEqual("marker row", mkRow, markerRow);
        expectEqual("marker column", mkCol, markerColumn);
        for (int k = 0; k < DebrisKinds; k++) begin
            expectEqual("debris row", dbRow[k], debrisRows[k]);
            expectEqual("debris column", dbCol[k], debrisColumns[k]);
        end
    endtask

    // Requests use the cursor cell from before the move
    task automatic pressButtons(input logic [11:0] buttons);
        logic [2:0] debrisButtons;
        logic onFree;
        debrisButtons = {buttons[ButtonZ], buttons[ButtonY], buttons[ButtonX]};
        while (!isRead(frameCount + 1)) begin
            runFrame('0, 1'b0, 1'b0, 1'b0);
        end
        runFrame(buttons, 1'b0, 1'b0, 1'b0);
        onFree = freeCell(curRow, curCol);
        if (buttons[ButtonA] && (onFree || (curRow == mkRow && curCol == mkCol))) begin
            robRow = curRow;
            robCol = curCol;
        end
        if (buttons[ButtonB] && onFree) begin
            mkRow = curRow;
            mkCol = curCol;
        end
        for (int k = 0; k < DebrisKinds; k++) begin
            if (debrisButtons[k] && onFree && dbRow[k] == ParkedPosition &&
                dbCol[k] == ParkedPosition) begin
                dbRow[k] = curRow;
                dbCol[k] = curCol;
            end
        end
        if (buttons[ButtonUp]) begin
            curRow = (curRow + MazeRows - 1) % MazeRows;
        end else if (buttons[ButtonDown]) begin
            curRow = (curRow + 1) % MazeRows;
        end
        if (buttons[ButtonLeft]) begin
            curCol = (curCol + MazeColumns - 1) % MazeColumns;
        end else if (buttons[ButtonRight]) begin
            curCol = (curCol + 1) % MazeColumns;
        end
        checkScene();
    endtask

    task automatic senseStep();
        int aheadRow;
        int aheadColumn;
        int sideRow;
        int sideColumn;
        int slot;
        headingT sideHeading;
        while (!isSense(frameCount + 1)) begin
            runFrame('0, 1'b0, 1'b0, 1'b0);
        end
        runFrame('0, 1'b0, 1'b0, 1'b0);
        awaitActive(1'b1);
        aheadRow = robRow + rowStep(robHead);
        aheadColumn = robCol + columnStep(robHead);
        sideHeading = turnedLeft(robHead);
        sideRow = robRow + rowStep(sideHeading);
        sideColumn = robCol + columnStep(sideHeading);
        slot = debrisAt(aheadRow, aheadColumn);
        if (slot >= 0 && lifeModel == 0) begin
            lifeModel = lifeOf(slot);
        end
        expectEqual("head", blocked(aheadRow, aheadColumn), head);
        expectEqual("left", blocked(sideRow, sideColumn), left);
        expectEqual("under", robRow == mkRow && robCol == mkCol, under);
        expectEqual("barrier", slot >= 0, barrier);
    endtask

    task automatic moveStep(input logic fwd, input logic turn, input logic wear);
        int aheadRow;
        int aheadColumn;
        int slot;
        while (!isMove(frameCount + 1)) begin
            runFrame('0, 1'b0, 1'b0, 1'b0);
        end
        runFrame('0, fwd, turn, wear);
        awaitActive(1'b0);
        aheadRow = robRow + rowStep(robHead);
        aheadColumn = robCol + columnStep(robHead);
        slot = debrisAt(aheadRow, aheadColumn);
        if (wear && lifeModel > 0) begin
            lifeModel--;
            // Worn out debris goes back to its parked slot
            if (lifeModel == 0 && slot >= 0) begin
                dbRow[slot] = ParkedPosition;
                dbCol[slot] = ParkedPosition;
            end
        end
        if (fwd) begin
            if (!offGrid(aheadRow, aheadColumn)) begin
                robRow = aheadRow;
                robCol = aheadColumn;
            end
        end else if (turn) begin
            robHead = turnedLeft(robHead);
        end
        checkScene();
    endtask

    task automatic resetTest();
        testName = "reset";
        checkScene();
        expectEqual("robotActive", 0, robotActive);
        expectEqual("sensors", 0, {head, left, under, barrier});
    endtask

    task automatic senseTurnTest();
        testName = "senseTurn";
        senseStep();
        moveStep(1'b0, 1'b1, 1'b0);
        expectEqual("heading after turn", North, robotHeading);
    endtask

    task automatic cursorWrapTest();
        testName = "cursorWrap";
        repeat (4) pressButtons(12'b1 << ButtonUp);
        expectEqual("wrapped row", 9, cursorRow);
        while (curCol != MazeColumns - 1) begin
            pressButtons(12'b1 << ButtonRight);
        end
        pressButtons(12'b1 << ButtonRight);
        expectEqual("wrapped column", 0, cursorColumn);
    endtask

    // Cursor starts on the wall cell at row 9, column 0
    task automatic placementTest();
        testName = "placement";
        pressButtons(12'b1 << ButtonA);
        pressButtons(12'b1 << ButtonRight);
        pressButtons(12'b1 << ButtonA);
        pressButtons((12'b1 << ButtonB) | (12'b1 << ButtonLeft));
        pressButtons(12'b1 << ButtonB);
    endtask

    task automatic debrisTest();
        testName = "debris";
        pressButtons((12'b1 << ButtonUp) | (12'b1 << ButtonRight));
        pressButtons(12'b1 << ButtonX);
        for (int hit = 0; hit < 3; hit++) begin
            senseStep();
            expectEqual("barrier ahead", 1, barrier);
            moveStep(1'b0, 1'b0, 1'b1);
        end
        expectEqual("parked row", ParkedPosition, debrisRows[0]);
        expectEqual("parked column", ParkedPosition, debrisColumns[0]);
        pressButtons(12'b1 << ButtonX);
    endtask

    task automatic advanceTest();
        testName = "advance";
        senseStep();
        moveStep(1'b1, 1'b0, 1'b0);
    endtask

    // Off the marker, then facing a wall with open floor to the left
    task automatic sensorTest();
        testName = "sensors";
        senseStep();
        moveStep(1'b0, 1'b1, 1'b0);
        senseStep();
    endtask

    initial begin
        Clock50 = 1'b0;
        reset = 1'b1;
        vSync = 1'b0;
        gamepad = '0;
        avancar = 1'b0;
        girar = 1'b0;
        remover = 1'b0;
        curRow = 3;
        curCol = 10;
        robRow = 3;
        robCol = 18;
        robHead = East;
        mkRow = 3;
        mkCol = 18;
        for (int k = 0; k < DebrisKinds; k++) begin
            dbRow[k] = ParkedPosition;
            dbCol[k] = ParkedPosition;
        end
        lifeModel = 0;
        frameCount = 0;
        errorCount = 0;
        checkCount = 0;
        repeat (3) @(posedge Clock50);
        #1;
        reset = 1'b0;
        resetTest();
        senseTurnTest();
        cursorWrapTest();
        placementTest();
        debrisTest();
        advanceTest();
        sensorTest();
        finishRun();
    end

endmodule

//--- sim.f
hdl/mazePkg.sv
hdl/robotPkg.sv
hdl/frameTiming.sv
hdl/commandReader.sv
hdl/worldState.sv
hdl/robotCore.sv
hdl/robotMazeTop.sv
sim/robotMazeTb.sv
